//--- hw/alu_engine_pkg.sv
// Package with field widths, field type, operation codes and config register addresses

package alu_engine_pkg;

  // --------------------------------------------------------------------------
  // Packet geometry
  // --------------------------------------------------------------------------

  // Width of one packet field
  parameter int FIELD_WIDTH = 32;

  // Default number of fields per engine packet
  parameter int DEFAULT_NUM_FIELDS = 4;

  // One field value, also used for constant and write data
  typedef logic [FIELD_WIDTH-1:0] field_t;

  // --------------------------------------------------------------------------
  // ALU operation codes
  // --------------------------------------------------------------------------

  // Codes 6 and 7 are unused and behave like NOP
  typedef enum logic [2:0] {
    // Operand packet straight through
    ALU_NOP = 3'd0,
    // Sum of the selected field pair
    ALU_ADD = 3'd1,
    // Absolute difference of the pair
    ALU_SUB = 3'd2,
    // Product of the pair, low half kept
    ALU_MUL = 3'd3,
    // Running sum over valid beats
    ALU_ACC = 3'd4,
    // No divider in this stage, operands pass through
    ALU_DIV = 3'd5
  } op_code_t;

  // --------------------------------------------------------------------------
  // Configuration register map
  // --------------------------------------------------------------------------

  // Register address on the write port
  typedef logic [2:0] cfg_addr_t;

  // Operation code, low 3 bits of write data
  localparam cfg_addr_t CFG_OP          = 3'd0;

  // Field pair / accumulate select
  localparam cfg_addr_t CFG_ALU_MASK    = 3'd1;

  // Fields replaced by the constant
  localparam cfg_addr_t CFG_CONST_MASK  = 3'd2;

  // The constant itself
  localparam cfg_addr_t CFG_CONST_VALUE = 3'd3;

  // Operand routing, one group of NUM_FIELDS bits per field
  // Wider than one word for large packets, then loaded high word first
  localparam cfg_addr_t CFG_OPS_MASK    = 3'd4;

endpackage : alu_engine_pkg

//--- hw/alu_config_regs.sv
// Configuration register block: operation code, masks and constant, loaded by write strobe

module alu_config_regs #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                                 ap_clk,
  input  logic                                 areset,
  input  logic                                 cfg_write,
  input  alu_engine_pkg::cfg_addr_t            cfg_addr,
  input  alu_engine_pkg::field_t               cfg_wdata,
  output alu_engine_pkg::op_code_t             alu_op,
  output logic [NUM_FIELDS-1:0]                alu_mask,
  output logic [NUM_FIELDS-1:0]                const_mask,
  output logic [NUM_FIELDS*NUM_FIELDS-1:0]     ops_mask,
  output alu_engine_pkg::field_t               const_value
);

  import alu_engine_pkg::*;

  // --------------------------------------------------------------------------
  // Local widths
  // --------------------------------------------------------------------------

  // Full routing mask, one group per field
  localparam int OPS_MASK_W = NUM_FIELDS * NUM_FIELDS;

  // Field-wide mask
  typedef logic [NUM_FIELDS-1:0] field_mask_t;

  // Routing mask with a write word appended below it
  typedef logic [OPS_MASK_W+FIELD_WIDTH-1:0] ops_shift_t;

  // Old mask shifted up by one word, new word at the bottom
  // For up to 32 mask bits this is just the low bits of the write data
  ops_shift_t ops_shift;

  assign ops_shift = {ops_mask, cfg_wdata};

  // --------------------------------------------------------------------------
  // Register write decode
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      alu_op      <= ALU_NOP;
      alu_mask    <= '0;
      const_mask  <= '0;
      ops_mask    <= '0;
      const_value <= '0;
    end else if (cfg_write) begin
      case (cfg_addr)
        CFG_OP: begin
          // Codes 6 and 7 are kept as written
          alu_op <= op_code_t'(cfg_wdata[2:0]);
        end
        CFG_ALU_MASK: begin
          alu_mask <= field_mask_t'(cfg_wdata[NUM_FIELDS-1:0]);
        end
        CFG_CONST_MASK: begin
          const_mask <= field_mask_t'(cfg_wdata[NUM_FIELDS-1:0]);
        end
        CFG_CONST_VALUE: begin
          const_value <= cfg_wdata;
        end
        CFG_OPS_MASK: begin
          ops_mask <= ops_shift[OPS_MASK_W-1:0];
        end
        default: begin
          // Unknown address, nothing written
        end
      endcase
    end
  end

endmodule : alu_config_regs

//--- hw/alu_operand_select.sv
// Operand select stage: routes input fields or the constant into operand and original packets

module alu_operand_select #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                                               ap_clk,
  input  logic                                               areset,
  input  logic                                               data_valid,
  input  logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  data_in,
  input  logic [NUM_FIELDS*NUM_FIELDS-1:0]                   ops_mask,
  input  logic [NUM_FIELDS-1:0]                              const_mask,
  input  alu_engine_pkg::field_t                             const_value,
  output logic                                               ops_valid,
  output logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  ops_value,
  output logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  org_value
);

  import alu_engine_pkg::*;

  // Whole engine packet
  typedef logic [NUM_FIELDS*FIELD_WIDTH-1:0] packet_t;

  // One routing group, bit j selects input field j
  typedef logic [NUM_FIELDS-1:0] group_t;

  packet_t ops_next;
  packet_t org_next;
  group_t  group;
  field_t  routed;

  // --------------------------------------------------------------------------
  // Routing per field
  // --------------------------------------------------------------------------

  always_comb begin
    ops_next = '0;
    org_next = '0;
    group    = '0;
    routed   = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      group = ops_mask[i*NUM_FIELDS +: NUM_FIELDS];

      // Own field unless the group picks another one
      routed = data_in[i*FIELD_WIDTH +: FIELD_WIDTH];

      // Ascending scan, so the highest set bit wins
      for (int j = 0; j < NUM_FIELDS; j++) begin
        if (group[j]) begin
          routed = data_in[j*FIELD_WIDTH +: FIELD_WIDTH];
        end
      end

      // Original value always follows the routing
      org_next[i*FIELD_WIDTH +: FIELD_WIDTH] = routed;

      // Constant beats routing, empty group gives zero
      if (const_mask[i]) begin
        ops_next[i*FIELD_WIDTH +: FIELD_WIDTH] = const_value;
      end else if (|group) begin
        ops_next[i*FIELD_WIDTH +: FIELD_WIDTH] = routed;
      end else begin
        ops_next[i*FIELD_WIDTH +: FIELD_WIDTH] = '0;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stage 1 registers
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ops_valid <= 1'b0;
    end else begin
      ops_valid <= data_valid;
    end
  end

  // Payload follows every cycle
  always_ff @(posedge ap_clk) begin
    ops_value <= ops_next;
    org_value <= org_next;
  end

endmodule : alu_operand_select

//--- hw/alu_ops_kernel.sv
// ALU kernel: pair operations, accumulate and clear, original delay, output merge and valid pipe

module alu_ops_kernel #(
  parameter int NUM_FIELDS = 4
) (
  input  logic                                               ap_clk,
  input  logic                                               areset,
  input  logic                                               clear,
  input  alu_engine_pkg::op_code_t                           alu_op,
  input  logic [NUM_FIELDS-1:0]                              alu_mask,
  input  logic                                               ops_valid,
  input  logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  ops_value,
  input  logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  org_value,
  output logic                                               result_valid,
  output logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  result_out
);

  import alu_engine_pkg::*;

  // Whole engine packet
  typedef logic [NUM_FIELDS*FIELD_WIDTH-1:0] packet_t;

  // Scalar placed in field 0, all other fields zero
  function automatic packet_t to_packet(input field_t value);
    packet_t pkt;
    pkt = '0;
    pkt[FIELD_WIDTH-1:0] = value;
    return pkt;
  endfunction

  // Held result and the originals of the same item
  packet_t result_reg;
  packet_t result_next;
  packet_t org_value_reg;
  logic    result_valid_pre;

  // Selected pair and accumulate operand
  logic    pair_hit;
  field_t  op_a;
  field_t  op_b;
  logic    acc_hit;
  field_t  acc_operand;

  // Candidate scalar results
  field_t  pair_sum;
  field_t  pair_diff;
  field_t  pair_prod;
  field_t  acc_sum;

  // --------------------------------------------------------------------------
  // Operand pick from alu_mask
  // --------------------------------------------------------------------------

  // Pair k, k+1 with k the highest set bit below the last field
  always_comb begin
    pair_hit = 1'b0;
    op_a     = '0;
    op_b     = '0;
    for (int i = 0; i < NUM_FIELDS-1; i++) begin
      if (alu_mask[i]) begin
        pair_hit = 1'b1;
        op_a     = ops_value[i*FIELD_WIDTH +: FIELD_WIDTH];
        op_b     = ops_value[(i+1)*FIELD_WIDTH +: FIELD_WIDTH];
      end
    end
  end

  // Accumulate may use any field, last one included
  always_comb begin
    acc_hit     = 1'b0;
    acc_operand = '0;
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (alu_mask[i]) begin
        acc_hit     = 1'b1;
        acc_operand = ops_value[i*FIELD_WIDTH +: FIELD_WIDTH];
      end
    end
  end

  assign pair_sum  = op_a + op_b;
  // Larger minus smaller, never wraps
  assign pair_diff = (op_a > op_b) ? (op_a - op_b) : (op_b - op_a);
  // Low 32 bits of the product
  assign pair_prod = op_a * op_b;
  assign acc_sum   = result_reg[FIELD_WIDTH-1:0] + acc_operand;

  // --------------------------------------------------------------------------
  // Operation select
  // --------------------------------------------------------------------------

  always_comb begin
    // Hold by default
    result_next = result_reg;
    case (alu_op)
      ALU_ADD: begin
        if (pair_hit) begin
          result_next = to_packet(pair_sum);
        end
      end
      ALU_SUB: begin
        if (pair_hit) begin
          result_next = to_packet(pair_diff);
        end
      end
      ALU_MUL: begin
        if (pair_hit) begin
          result_next = to_packet(pair_prod);
        end
      end
      ALU_ACC: begin
        // Grows only on valid beats
        if (ops_valid && acc_hit) begin
          result_next = to_packet(acc_sum);
        end
      end
      default: begin
        // NOP, DIV and unused codes
        result_next = ops_value;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Stage 2: result and aligned originals
  // --------------------------------------------------------------------------

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      result_reg <= '0;
    end else if (clear) begin
      // Clear wins over any operation this cycle
      result_reg <= '0;
    end else begin
      result_reg <= result_next;
    end
  end

  always_ff @(posedge ap_clk) begin
    org_value_reg <= org_value;
  end

  // --------------------------------------------------------------------------
  // Stage 3: output merge
  // --------------------------------------------------------------------------

  // Low half from the result, high half from the originals
  always_ff @(posedge ap_clk) begin
    for (int i = 0; i < NUM_FIELDS; i++) begin
      if (i < NUM_FIELDS/2) begin
        result_out[i*FIELD_WIDTH +: FIELD_WIDTH] <= result_reg[i*FIELD_WIDTH +: FIELD_WIDTH];
      end else begin
        result_out[i*FIELD_WIDTH +: FIELD_WIDTH] <= org_value_reg[i*FIELD_WIDTH +: FIELD_WIDTH];
      end
    end
  end

  // Two-stage valid pipe to match the data path
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      result_valid_pre <= 1'b0;
      result_valid     <= 1'b0;
    end else begin
      result_valid_pre <= ops_valid;
      result_valid     <= result_valid_pre;
    end
  end

endmodule : alu_ops_kernel

//--- hw/alu_engine_top.sv
// Field ALU engine top: config registers, operand select stage and ALU kernel

module alu_engine_top #(
  parameter int NUM_FIELDS = alu_engine_pkg::DEFAULT_NUM_FIELDS
) (
  input  logic                                               ap_clk,
  input  logic                                               areset,
  input  logic                                               clear,
  input  logic                                               cfg_write,
  input  alu_engine_pkg::cfg_addr_t                          cfg_addr,
  input  alu_engine_pkg::field_t                             cfg_wdata,
  input  logic                                               data_valid,
  input  logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  data_in,
  output logic                                               result_valid,
  output logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  result_out
);

  import alu_engine_pkg::*;

  // Configuration towards the pipeline
  op_code_t                            alu_op;
  logic [NUM_FIELDS-1:0]               alu_mask;
  logic [NUM_FIELDS-1:0]               const_mask;
  logic [NUM_FIELDS*NUM_FIELDS-1:0]    ops_mask;
  field_t                              const_value;

  // Stage 1 to kernel
  logic                                ops_valid;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0]   ops_value;
  logic [NUM_FIELDS*FIELD_WIDTH-1:0]   org_value;

  alu_config_regs #(.NUM_FIELDS(NUM_FIELDS)) u_config_regs (
    .ap_clk, .areset, .cfg_write, .cfg_addr, .cfg_wdata,
    .alu_op, .alu_mask, .const_mask, .ops_mask, .const_value
  );

  // One cycle of routing
  alu_operand_select #(.NUM_FIELDS(NUM_FIELDS)) u_operand_select (
    .ap_clk, .areset, .data_valid, .data_in,
    .ops_mask, .const_mask, .const_value,
    .ops_valid, .ops_value, .org_value
  );

  // Two cycles of operation and merge
  alu_ops_kernel #(.NUM_FIELDS(NUM_FIELDS)) u_ops_kernel (
    .ap_clk, .areset, .clear, .alu_op, .alu_mask,
    .ops_valid, .ops_value, .org_value,
    .result_valid, .result_out
  );

endmodule : alu_engine_top

//--- verification/tb_clock_gen.sv
// Testbench clock and reset generator: free-running clock, reset held for a few rising edges

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 3
) (
  output logic ap_clk,
  output logic areset
);
  timeunit 1ns;
  timeprecision 1ps;

  // Clock starts low, first rising edge half a period in
  initial begin
    ap_clk = 1'b0;
    forever #(PERIOD_NS / 2) ap_clk = ~ap_clk;
  end

  // Released on the last reset edge, so the DUT sees RESET_CYCLES edges with reset high
  initial begin
    areset = 1'b1;
    repeat (RESET_CYCLES) @(posedge ap_clk);
    areset <= 1'b0;
  end

endmodule : tb_clock_gen

//--- verification/alu_engine_sva.sv
// Bound assertions: valid low after reset, three-cycle valid latency, known output data

module alu_engine_sva #(
  parameter int NUM_FIELDS = 4
) (
  input logic                                               ap_clk,
  input logic                                               areset,
  input logic                                               data_valid,
  input logic                                               result_valid,
  input logic [NUM_FIELDS*alu_engine_pkg::FIELD_WIDTH-1:0]  result_out
);
  timeunit 1ns;
  timeprecision 1ps;

  // Count of failed properties
  int unsigned error_count = 0;

  // Valid pipe cleared by reset
  reset_clears_valid: assert property (
    @(posedge ap_clk) areset |=> !result_valid
  ) else begin
    error_count++;
    $error("result_valid high in the cycle after reset");
  end

  // One stage in operand select, two in the kernel
  valid_latency: assert property (
    @(posedge ap_clk) disable iff (areset) data_valid |-> ##3 result_valid
  ) else begin
    error_count++;
    $error("result_valid missing 3 cycles after data_valid");
  end

  // No result without an input 3 cycles back
  no_extra_valid: assert property (
    @(posedge ap_clk) disable iff (areset) result_valid |-> $past(data_valid, 3)
  ) else begin
    error_count++;
    $error("result_valid without data_valid 3 cycles earlier");
  end

  // Payload fully known whenever it is flagged valid
  known_result: assert property (
    @(posedge ap_clk) disable iff (areset) result_valid |-> !$isunknown(result_out)
  ) else begin
    error_count++;
    $error("result_out has unknown bits while result_valid is high");
  end

endmodule : alu_engine_sva

//--- verification/alu_engine_tb.sv
// Testbench top for the field ALU engine: test file reader, stimulus, result checks, watchdog

module alu_engine_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import alu_engine_pkg::*;

  localparam int    NUM_FIELDS = 4;
  localparam string TEST_FILE  = "verification/alu_engine_tests.txt";

  // Whole engine packet in the DUT port layout
  typedef logic [NUM_FIELDS*FIELD_WIDTH-1:0] packet_t;

  logic      ap_clk;
  logic      areset;
  logic      clear;
  logic      cfg_write;
  cfg_addr_t cfg_addr;
  field_t    cfg_wdata;
  logic      data_valid;
  packet_t   data_in;
  logic      result_valid;
  packet_t   result_out;

  // Test file and run state
  string   lines[$];
  bit      load_done;
  bit      after_beat;
  string   test_name;
  int      seed;
  int      data_count;
  int      result_count;

  // Expectations in issue order
  packet_t exp_q[$];
  string   name_q[$];

  tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(3)) clk0 (.ap_clk, .areset);

  alu_engine_top #(.NUM_FIELDS(NUM_FIELDS)) dut0 (
    .ap_clk, .areset, .clear, .cfg_write, .cfg_addr, .cfg_wdata,
    .data_valid, .data_in, .result_valid, .result_out
  );

  bind alu_engine_top alu_engine_sva #(.NUM_FIELDS(NUM_FIELDS)) sva0 (
    .ap_clk, .areset, .data_valid, .result_valid, .result_out
  );

  // --------------------------------------------------------------------------
  // Reporting and checks
  // --------------------------------------------------------------------------

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_packet(input string name, input packet_t expected, input packet_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_valid(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("FAILED %s: expected valid %b, actual %b",
                               name, expected, actual));
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus, one task per kind of cycle
  // --------------------------------------------------------------------------

  task automatic idle_cycle();
    @(posedge ap_clk);
    cfg_write  <= 1'b0;
    data_valid <= 1'b0;
    clear      <= 1'b0;
  endtask

  task automatic write_config(input cfg_addr_t addr, input field_t wdata);
    @(posedge ap_clk);
    cfg_write  <= 1'b1;
    cfg_addr   <= addr;
    cfg_wdata  <= wdata;
    data_valid <= 1'b0;
    clear      <= 1'b0;
  endtask

  task automatic send_beat(input logic clr, input packet_t pkt);
    @(posedge ap_clk);
    cfg_write  <= 1'b0;
    data_valid <= 1'b1;
    data_in    <= pkt;
    clear      <= clr;
  endtask

  task automatic load_tests();
    int    fd;
    string line;
    fd = $fopen(TEST_FILE, "r");
    if (fd == 0) begin
      report_failure($sformatf("Error: cannot open test file %s", TEST_FILE));
    end
    while (!$feof(fd)) begin
      line = "";
      if ($fgets(line, fd) > 0) begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    load_done = 1'b1;
  endtask

  // T name / W addr data / D clear in3..in0 exp3..exp0
  task automatic run_line(input string line);
    int          n;
    int          gap;
    logic [31:0] addr;
    field_t      wdata;
    logic [31:0] clr;
    field_t      in_f[NUM_FIELDS];
    field_t      exp_f[NUM_FIELDS];
    case (line.getc(0))
      "T": begin
        n = $sscanf(line, "T %s", test_name);
        if (n != 1) report_failure($sformatf("Error: test line without a name: %s", line));
      end
      "W": begin
        n = $sscanf(line, "W %h %h", addr, wdata);
        if (n != 2) report_failure($sformatf("Error: malformed write line: %s", line));
        // Config must not change under items in flight
        if (after_beat) repeat (4) idle_cycle();
        after_beat = 1'b0;
        write_config(cfg_addr_t'(addr), wdata);
      end
      "D": begin
        n = $sscanf(line, "D %h %h %h %h %h %h %h %h %h", clr,
                    in_f[3], in_f[2], in_f[1], in_f[0],
                    exp_f[3], exp_f[2], exp_f[1], exp_f[0]);
        if (n != 9) report_failure($sformatf("Error: malformed data line: %s", line));
        gap = $unsigned($random(seed)) % 3;
        // Clear zeroes the held result as soon as it is sampled
        // One idle cycle lets the item ahead accumulate first
        if (clr[0] && gap == 0) gap = 1;
        repeat (gap) idle_cycle();
        exp_q.push_back({exp_f[3], exp_f[2], exp_f[1], exp_f[0]});
        name_q.push_back(test_name);
        data_count++;
        after_beat = 1'b1;
        send_beat(clr[0], {in_f[3], in_f[2], in_f[1], in_f[0]});
      end
      default: begin
        // Comment or blank line
      end
    endcase
  endtask

  // --------------------------------------------------------------------------
  // Result collector on the falling edge
  // --------------------------------------------------------------------------

  always @(negedge ap_clk) begin
    if (result_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        report_failure("Error: result_valid high with no result pending");
      end else begin
        check_packet(name_q.pop_front(), exp_q.pop_front(), result_out);
        result_count++;
      end
    end
  end

  // Bound checker failures
  always @(negedge ap_clk) begin
    if (dut0.sva0.error_count != 0) begin
      report_failure("Error: an assertion in the bound checker failed");
    end
  end

  // Limit scales with the length of the test file
  initial begin : watchdog
    wait (load_done);
    repeat (lines.size() * 8 + 50) @(posedge ap_clk);
    report_failure("Error: timeout, the run did not finish in time");
  end

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin : main
    seed         = 78726;
    cfg_write    = 1'b0;
    cfg_addr     = '0;
    cfg_wdata    = '0;
    data_valid   = 1'b0;
    data_in      = '0;
    clear        = 1'b0;
    test_name    = "reset";
    after_beat   = 1'b0;
    data_count   = 0;
    result_count = 0;
    load_tests();
    while (areset !== 1'b0) @(posedge ap_clk);
    repeat (2) begin
      @(negedge ap_clk);
      check_valid("after reset", 1'b0, result_valid);
    end
    foreach (lines[i]) begin
      run_line(lines[i]);
    end
    idle_cycle();
    // Last result is due 3 cycles after its beat
    repeat (3) @(negedge ap_clk);
    repeat (4) begin
      @(negedge ap_clk);
      check_valid("idle after last beat", 1'b0, result_valid);
    end
    if (result_count == data_count) begin
      $display("TB PASSED");
      $finish;
    end else begin
      report_failure($sformatf("Error: %0d results for %0d data lines",
                               result_count, data_count));
    end
  end

endmodule : alu_engine_tb

//--- verification/alu_engine_tests.txt
# T name | W addr data (hex) | D clear in3 in2 in1 in0 exp3 exp2 exp1 exp0 (hex)
# Registers keep their value from one test to the next
T pass_through
W 4 00004812
W 2 00000002
W 3 5A5A0001
D 0 A3333333 A2222222 A1111111 A0000000 A2222222 A3333333 5A5A0001 A1111111
D 0 00000004 00000003 00000002 00000001 00000003 00000004 5A5A0001 00000002
T add
W 4 00008421
W 2 00000000
W 1 00000001
W 0 00000001
D 0 00000030 00000020 00000100 00000023 00000030 00000020 00000000 00000123
D 0 13572468 24681357 FFFFFFFF 00000002 13572468 24681357 00000000 00000001
T sub
W 1 00000002
W 0 00000002
D 0 00000077 00000400 00001000 99999999 00000077 00000400 00000000 00000C00
D 0 00000001 80000000 00000005 00000000 00000001 80000000 00000000 7FFFFFFB
T mul
W 1 00000004
W 0 00000003
D 0 00000003 00010001 00000002 00000001 00000003 00010001 00000000 00030003
D 0 00010003 00010000 00000002 00000001 00010003 00010000 00000000 00030000
T mask_priority
W 4 00008321
W 1 0000000F
W 0 00000001
D 0 00000100 00000010 00000002 00000001 00000100 00000002 00000000 00000102
T acc
W 4 00008421
W 1 00000009
W 0 00000004
D 1 00000010 0000000A 00000001 00000002 00000010 0000000A 00000000 00000010
D 0 00000020 0000000B 00000001 00000002 00000020 0000000B 00000000 00000030
D 0 00000005 0000000C 00000001 00000002 00000005 0000000C 00000000 00000035
D 1 00000007 0000000D 00000001 00000002 00000007 0000000D 00000000 00000007
D 0 00000100 0000000E 00000001 00000002 00000100 0000000E 00000000 00000107

//--- sim.f
hw/alu_engine_pkg.sv
hw/alu_config_regs.sv
hw/alu_operand_select.sv
hw/alu_ops_kernel.sv
hw/alu_engine_top.sv
verification/tb_clock_gen.sv
verification/alu_engine_sva.sv
verification/alu_engine_tb.sv
